//--- logic/periph_defines.svh
// widths, address map and register indexes; all accesses are full 32-bit words
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

`define DATA_W      32
`define ADDR_W      16
`define SLOT_LSB    12
`define REG_LSB     2
`define GPIO_W      8
`define GPIO_EXT_W  6
`define CS_NUM      2

// peripheral slots, slot 3 is unmapped
`define SLOT_SPI    2'd0
`define SLOT_UART   2'd1
`define SLOT_GPIO   2'd2

// spi and uart registers
`define REG_DATA     3'd0
`define REG_STATUS   3'd1
`define REG_DIV      3'd2
`define REG_CS       3'd3

// gpio registers
`define REG_GPIO_IN   3'd0
`define REG_GPIO_OUT  3'd1
`define REG_GPIO_OE   3'd2
`define REG_IRQ_EN    3'd3
`define REG_IRQ_PEND  3'd4

// status bits
`define STAT_BUSY  0
`define STAT_DONE  1

`endif

//--- logic/periph_pkg.sv
// shared types for the apb peripherals; widths follow periph_defines.svh
`include "periph_defines.svh"

package periph_pkg;

  typedef logic [`DATA_W-1:0]  word_t;
  typedef logic [`ADDR_W-1:0]  addr_t;
  typedef logic [7:0]          byte_t;
  typedef logic [15:0]         div_t;
  typedef logic [2:0]          reg_idx_t;
  typedef logic [1:0]          slot_t;
  typedef logic [`GPIO_W-1:0]  gpio_t;

  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef enum logic {SPI_IDLE, SPI_SHIFT} spi_state_t;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

//--- logic/apb_decoder.sv
// zero wait-state apb decode into three slots; slot 3 answers with pslverr
`timescale 1ns/1ps
`include "periph_defines.svh"

module apb_decoder import periph_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  output apb_req_t spi_req,
  output apb_req_t uart_req,
  output apb_req_t gpio_req,
  input  apb_rsp_t spi_rsp,
  input  apb_rsp_t uart_rsp,
  input  apb_rsp_t gpio_rsp
);

  slot_t slot;

  assign slot = req.paddr[`SLOT_LSB +: 2];

  // same request everywhere, psel only on the addressed slot
  always_comb begin
    spi_req       = req;
    uart_req      = req;
    gpio_req      = req;
    spi_req.psel  = req.psel && (slot == `SLOT_SPI);
    uart_req.psel = req.psel && (slot == `SLOT_UART);
    gpio_req.psel = req.psel && (slot == `SLOT_GPIO);
  end

  always_comb begin
    case (slot)
      `SLOT_SPI:  rsp = spi_rsp;
      `SLOT_UART: rsp = uart_rsp;
      `SLOT_GPIO: rsp = gpio_rsp;
      default: begin
        // unmapped slot
        rsp.prdata  = '0;
        rsp.pready  = 1'b1;
        rsp.pslverr = 1'b1;
      end
    endcase
  end

  a_one_psel: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({spi_req.psel, uart_req.psel, gpio_req.psel}));

endmodule

//--- logic/spi_master.sv
// spi mode 0, msb first, one byte per DATA write; chip selects are software driven
`timescale 1ns/1ps
`include "periph_defines.svh"

module spi_master import periph_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  apb_req_t           req,
  output apb_rsp_t           rsp,
  output logic               spi_clk,
  output logic               spi_mosi,
  output logic [`CS_NUM-1:0] spi_cs,
  input  logic               spi_miso,
  output logic               irq
);

  spi_state_t         state;
  div_t               div;
  logic [`CS_NUM-1:0] cs;
  byte_t              shreg;
  div_t               div_cnt;
  logic [3:0]         bit_cnt;
  logic               done;
  logic               busy;
  logic [1:0]         status;
  reg_idx_t           idx;
  logic               wr;
  logic               start;
  logic               tick;

  assign idx   = req.paddr[`REG_LSB +: 3];
  assign wr    = req.psel && req.penable && req.pwrite;
  assign busy  = (state != SPI_IDLE);
  assign start = wr && (idx == `REG_DATA) && !busy;
  assign tick  = busy && (div_cnt == div);

  assign status[`STAT_BUSY] = busy;
  assign status[`STAT_DONE] = done;

  assign spi_cs = ~cs;
  assign irq    = done;

  always_comb begin
    rsp.pready  = 1'b1;
    rsp.pslverr = wr && (idx == `REG_DATA) && busy;
    case (idx)
      `REG_DATA:   rsp.prdata = word_t'(shreg);
      `REG_STATUS: rsp.prdata = word_t'(status);
      `REG_DIV:    rsp.prdata = word_t'(div);
      `REG_CS:     rsp.prdata = word_t'(cs);
      default:     rsp.prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= SPI_IDLE;
      div      <= '0;
      cs       <= '0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      done     <= 1'b0;
      spi_clk  <= 1'b0;
      spi_mosi <= 1'b0;
    end else begin
      if (wr && idx == `REG_DIV)
        div <= req.pwdata[15:0];
      if (wr && idx == `REG_CS)
        cs <= req.pwdata[`CS_NUM-1:0];
      // write one to clear done
      if (wr && idx == `REG_STATUS && req.pwdata[`STAT_DONE])
        done <= 1'b0;
      case (state)
        SPI_IDLE: begin
          if (start) begin
            state    <= SPI_SHIFT;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            spi_mosi <= req.pwdata[7];
          end
        end
        SPI_SHIFT: begin
          if (!tick) begin
            div_cnt <= div_cnt + 1'b1;
          end else begin
            div_cnt <= '0;
            spi_clk <= !spi_clk;
            if (!spi_clk) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (bit_cnt == 4'd8) begin
              state <= SPI_IDLE;
              done  <= 1'b1;
            end else begin
              // next bit on the falling edge
              spi_mosi <= shreg[7];
            end
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // tx bits leave at the top, miso enters at the bottom on the rising edge
  always_ff @(posedge clk) begin
    if (start)
      shreg <= req.pwdata[7:0];
    else if (tick && !spi_clk)
      shreg <= {shreg[6:0], spi_miso};
  end

  a_clk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SPI_IDLE) |-> !spi_clk);
  a_bit_cnt: assert property (@(posedge clk) disable iff (!rst_n) bit_cnt <= 4'd8);

endmodule

//--- logic/uart_tx.sv
// uart transmitter, 8N1 lsb first, bit time is DIV+1 clocks; no receiver
`timescale 1ns/1ps
`include "periph_defines.svh"

module uart_tx import periph_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  output logic     tx,
  output logic     irq
);

  uart_state_t state;
  div_t        div;
  div_t        baud_cnt;
  logic [2:0]  bit_cnt;
  byte_t       shreg;
  logic        done;
  logic        busy;
  logic [1:0]  status;
  reg_idx_t    idx;
  logic        wr;
  logic        start;
  logic        tick;

  assign idx   = req.paddr[`REG_LSB +: 3];
  assign wr    = req.psel && req.penable && req.pwrite;
  assign busy  = (state != UART_IDLE);
  assign start = wr && (idx == `REG_DATA) && !busy;
  assign tick  = busy && (baud_cnt == div);

  assign status[`STAT_BUSY] = busy;
  assign status[`STAT_DONE] = done;
  assign irq = done;

  always_comb begin
    rsp.pready  = 1'b1;
    rsp.pslverr = wr && (idx == `REG_DATA) && busy;
    case (idx)
      `REG_STATUS: rsp.prdata = word_t'(status);
      `REG_DIV:    rsp.prdata = word_t'(div);
      default:     rsp.prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= UART_IDLE;
      div      <= '0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      done     <= 1'b0;
      tx       <= 1'b1;
    end else begin
      if (wr && idx == `REG_DIV)
        div <= req.pwdata[15:0];
      if (wr && idx == `REG_STATUS && req.pwdata[`STAT_DONE])
        done <= 1'b0;
      baud_cnt <= tick ? '0 : baud_cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          baud_cnt <= '0;
          if (start) begin
            state <= UART_START;
            tx    <= 1'b0;
          end
        end
        UART_START: begin
          if (tick) begin
            state   <= UART_DATA;
            bit_cnt <= '0;
            tx      <= shreg[0];
          end
        end
        UART_DATA: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= UART_STOP;
              tx    <= 1'b1;
            end else begin
              tx <= shreg[1];
            end
          end
        end
        UART_STOP: begin
          if (tick) begin
            state <= UART_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // bit 0 is always the one on the line during DATA
  always_ff @(posedge clk) begin
    if (start)
      shreg <= req.pwdata[7:0];
    else if (tick && state == UART_DATA)
      shreg <= shreg >> 1;
  end

  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) (state == UART_IDLE) |-> tx);

endmodule

//--- logic/gpio_apb.sv
// gpio with rising-edge interrupts; inputs are synchronized, so edges land a few clocks late
`timescale 1ns/1ps
`include "periph_defines.svh"

module gpio_apb import periph_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  input  gpio_t    gpio_in,
  output gpio_t    gpio_o,
  output gpio_t    gpio_oe,
  output logic     irq
);

  gpio_t    sync_q1;
  gpio_t    sync_q2;
  gpio_t    sync_last;
  gpio_t    rise;
  gpio_t    irq_en;
  gpio_t    irq_pend;
  reg_idx_t idx;
  logic     wr;

  assign idx  = req.paddr[`REG_LSB +: 3];
  assign wr   = req.psel && req.penable && req.pwrite;
  assign rise = sync_q2 & ~sync_last;

  always_comb begin
    rsp.pready  = 1'b1;
    rsp.pslverr = 1'b0;
    case (idx)
      `REG_GPIO_IN:  rsp.prdata = word_t'(sync_q2);
      `REG_GPIO_OUT: rsp.prdata = word_t'(gpio_o);
      `REG_GPIO_OE:  rsp.prdata = word_t'(gpio_oe);
      `REG_IRQ_EN:   rsp.prdata = word_t'(irq_en);
      `REG_IRQ_PEND: rsp.prdata = word_t'(irq_pend);
      default:       rsp.prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q1   <= '0;
      sync_q2   <= '0;
      sync_last <= '0;
      gpio_o    <= '0;
      gpio_oe   <= '0;
      irq_en    <= '0;
      irq_pend  <= '0;
      irq       <= 1'b0;
    end else begin
      sync_q1   <= gpio_in;
      sync_q2   <= sync_q1;
      sync_last <= sync_q2;
      if (wr && idx == `REG_GPIO_OUT)
        gpio_o <= req.pwdata[`GPIO_W-1:0];
      if (wr && idx == `REG_GPIO_OE)
        gpio_oe <= req.pwdata[`GPIO_W-1:0];
      if (wr && idx == `REG_IRQ_EN)
        irq_en <= req.pwdata[`GPIO_W-1:0];
      // a new edge wins over a clear in the same cycle
      if (wr && idx == `REG_IRQ_PEND)
        irq_pend <= (irq_pend & ~req.pwdata[`GPIO_W-1:0]) | rise;
      else
        irq_pend <= irq_pend | rise;
      irq <= |(irq_pend & irq_en);
    end
  end

endmodule

//--- logic/periph_top.sv
// apb peripheral subsystem on one clock; gpio lines 6 and 7 carry the uart and spi interrupts
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_top import periph_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  apb_req_t               apb_req,
  output apb_rsp_t               apb_rsp,
  output logic                   spi_clk,
  output logic                   spi_mosi,
  output logic [`CS_NUM-1:0]     spi_cs,
  input  logic                   spi_miso,
  output logic                   uart_tx,
  input  logic [`GPIO_EXT_W-1:0] gpio_i,
  output gpio_t                  gpio_o,
  output gpio_t                  gpio_oe,
  output logic                   irq
);

  apb_req_t spi_req;
  apb_req_t uart_req;
  apb_req_t gpio_req;
  apb_rsp_t spi_rsp;
  apb_rsp_t uart_rsp;
  apb_rsp_t gpio_rsp;
  logic     irq_spi;
  logic     irq_uart;
  gpio_t    gpio_in;

  // interrupt sources share the gpio edge logic
  assign gpio_in = {irq_spi, irq_uart, gpio_i};

  apb_decoder u_decoder (
    .clk(clk), .rst_n(rst_n), .req(apb_req), .rsp(apb_rsp),
    .spi_req(spi_req), .uart_req(uart_req), .gpio_req(gpio_req),
    .spi_rsp(spi_rsp), .uart_rsp(uart_rsp), .gpio_rsp(gpio_rsp)
  );

  spi_master u_spi (
    .clk(clk), .rst_n(rst_n), .req(spi_req), .rsp(spi_rsp),
    .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_cs(spi_cs),
    .spi_miso(spi_miso), .irq(irq_spi)
  );

  uart_tx u_uart (
    .clk(clk), .rst_n(rst_n), .req(uart_req), .rsp(uart_rsp),
    .tx(uart_tx), .irq(irq_uart)
  );

  gpio_apb u_gpio (
    .clk(clk), .rst_n(rst_n), .req(gpio_req), .rsp(gpio_rsp),
    .gpio_in(gpio_in), .gpio_o(gpio_o), .gpio_oe(gpio_oe), .irq(irq)
  );

endmodule

//--- bench/clock_gen.sv
// 40 ns clock from time zero; rst_n is released at the fourth rising edge
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- bench/periph_tb.sv
// directed tests of periph_top; spi_miso loops back to spi_mosi and the run ends at 4000 clocks
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_tb import periph_pkg::*; ();

  localparam int TIMEOUT = 4000;

  logic                   clk;
  logic                   rst_n;
  apb_req_t               apb_req;
  apb_rsp_t               apb_rsp;
  logic                   spi_clk;
  logic                   spi_mosi;
  logic [`CS_NUM-1:0]     spi_cs;
  logic                   uart_tx;
  logic [`GPIO_EXT_W-1:0] gpio_i;
  gpio_t                  gpio_o;
  gpio_t                  gpio_oe;
  logic                   irq;
  logic [31:0]            lfsr = 32'hc882a242;
  int                     cycles = 0;
  int                     errors = 0;
  int                     spi_edges = 0;
  byte_t                  spi_bits;

  clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  periph_top UUT (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_cs(spi_cs), .spi_miso(spi_mosi),
    .uart_tx(uart_tx), .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe(gpio_oe), .irq(irq)
  );

  // mode 0, mosi is stable at the rising spi_clk
  always @(posedge spi_clk) begin
    spi_bits = {spi_bits[6:0], spi_mosi};
    spi_edges = spi_edges + 1;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("ERROR: the tests did not finish within %0d clock cycles", TIMEOUT);
      stop_run();
    end
  end

  task automatic stop_run();
    errors = errors + 1;
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // galois form, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic next_byte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  function automatic addr_t reg_addr(input slot_t slot, input reg_idx_t idx);
    addr_t a;
    a = '0;
    a[`SLOT_LSB +: 2] = slot;
    a[`REG_LSB +: 3] = idx;
    return a;
  endfunction

  // setup, access, then idle; response sampled mid access cycle
  task automatic apb_xfer(input logic write, input addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    apb_req_t r;
    r.paddr   = addr;
    r.psel    = 1'b1;
    r.penable = 1'b0;
    r.pwrite  = write;
    r.pwdata  = wdata;
    @(posedge clk);
    apb_req <= r;
    r.penable = 1'b1;
    @(posedge clk);
    apb_req <= r;
    @(negedge clk);
    check_value(word_t'(apb_rsp.pready), 1, "pready in access cycle");
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input addr_t addr, input word_t data, output logic err);
    word_t unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input addr_t addr, output word_t data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ok(input addr_t addr, input word_t data);
    logic err;
    apb_write(addr, data, err);
    check_value(word_t'(err), 0, "pslverr on write");
  endtask

  task automatic read_check(input addr_t addr, input word_t exp, input string what);
    word_t data;
    logic  err;
    apb_read(addr, data, err);
    check_value(word_t'(err), 0, "pslverr on read");
    check_value(data, exp, what);
  endtask

  task automatic wait_reg(input addr_t addr, input word_t mask, input word_t value);
    word_t data;
    logic  err;
    apb_read(addr, data, err);
    while ((data & mask) !== value)
      apb_read(addr, data, err);
  endtask

  task automatic wait_irq(input logic level);
    while (irq !== level)
      @(negedge clk);
  endtask

  // tx falls at a clock edge, so mid-bit sits two clocks later with DIV 3
  task automatic capture_frame(output logic [9:0] frame);
    while (uart_tx !== 1'b0)
      @(negedge clk);
    repeat (2) @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      frame[i] = uart_tx;
      if (i < 9)
        repeat (4) @(negedge clk);
    end
  endtask

  task automatic registers_readback();
    write_ok(reg_addr(`SLOT_GPIO, `REG_GPIO_OUT), 32'h5a);
    write_ok(reg_addr(`SLOT_GPIO, `REG_GPIO_OE), 32'hc3);
    write_ok(reg_addr(`SLOT_SPI, `REG_DIV), 32'h0123);
    write_ok(reg_addr(`SLOT_SPI, `REG_CS), 32'h2);
    write_ok(reg_addr(`SLOT_UART, `REG_DIV), 32'h0456);
    read_check(reg_addr(`SLOT_GPIO, `REG_GPIO_OUT), 32'h5a, "gpio OUT");
    read_check(reg_addr(`SLOT_GPIO, `REG_GPIO_OE), 32'hc3, "gpio OE");
    read_check(reg_addr(`SLOT_SPI, `REG_DIV), 32'h0123, "spi DIV");
    read_check(reg_addr(`SLOT_SPI, `REG_CS), 32'h2, "spi CS");
    read_check(reg_addr(`SLOT_UART, `REG_DIV), 32'h0456, "uart DIV");
    read_check(reg_addr(`SLOT_SPI, 3'd5), 0, "unused spi register");
    read_check(reg_addr(`SLOT_GPIO, 3'd7), 0, "unused gpio register");
    @(negedge clk);
    check_value(word_t'(gpio_o), 32'h5a, "gpio_o pins");
    check_value(word_t'(gpio_oe), 32'hc3, "gpio_oe pins");
    check_value(word_t'(spi_cs), 32'h1, "spi_cs pins");
  endtask

  task automatic decode_error();
    word_t data;
    logic  err;
    apb_read(16'h3000, data, err);
    check_value(word_t'(err), 1, "pslverr on slot 3 read");
    check_value(data, 0, "prdata on slot 3 read");
    apb_read(16'h3ffc, data, err);
    check_value(word_t'(err), 1, "pslverr on slot 3 high read");
    check_value(data, 0, "prdata on slot 3 high read");
    apb_write(16'h3008, 32'hffffffff, err);
    check_value(word_t'(err), 1, "pslverr on slot 3 write");
    apb_read(reg_addr(`SLOT_GPIO, `REG_GPIO_OUT), data, err);
    check_value(word_t'(err), 0, "pslverr on mapped read");
  endtask

  task automatic spi_transfer();
    byte_t tx_byte;
    logic  err;
    next_byte(tx_byte);
    write_ok(reg_addr(`SLOT_SPI, `REG_DIV), 1);
    write_ok(reg_addr(`SLOT_SPI, `REG_CS), 1);
    @(negedge clk);
    check_value(word_t'(spi_cs), 32'h2, "spi_cs with device 0 selected");
    spi_edges = 0;
    write_ok(reg_addr(`SLOT_SPI, `REG_DATA), word_t'(tx_byte));
    apb_write(reg_addr(`SLOT_SPI, `REG_DATA), 32'h0, err);
    check_value(word_t'(err), 1, "pslverr on DATA write while busy");
    wait_reg(reg_addr(`SLOT_SPI, `REG_STATUS), 32'h1, 32'h0);
    check_value(spi_edges, 8, "spi_clk rising edges");
    check_value(word_t'(spi_bits), word_t'(tx_byte), "mosi bits, msb first");
    read_check(reg_addr(`SLOT_SPI, `REG_DATA), word_t'(tx_byte), "spi DATA loopback");
    read_check(reg_addr(`SLOT_SPI, `REG_STATUS), 32'h2, "spi STATUS done pending");
    write_ok(reg_addr(`SLOT_SPI, `REG_STATUS), 32'h2);
    read_check(reg_addr(`SLOT_SPI, `REG_STATUS), 32'h0, "spi STATUS after clear");
  endtask

  task automatic uart_frame();
    byte_t      tx_byte;
    logic [9:0] frame;
    next_byte(tx_byte);
    write_ok(reg_addr(`SLOT_UART, `REG_DIV), 3);
    write_ok(reg_addr(`SLOT_UART, `REG_DATA), word_t'(tx_byte));
    capture_frame(frame);
    check_value(word_t'(frame[0]), 0, "uart start bit");
    check_value(word_t'(frame[8:1]), word_t'(tx_byte), "uart data bits, lsb first");
    check_value(word_t'(frame[9]), 1, "uart stop bit");
    wait_reg(reg_addr(`SLOT_UART, `REG_STATUS), 32'h1, 32'h0);
    read_check(reg_addr(`SLOT_UART, `REG_STATUS), 32'h2, "uart STATUS done pending");
    write_ok(reg_addr(`SLOT_UART, `REG_STATUS), 32'h2);
    read_check(reg_addr(`SLOT_UART, `REG_STATUS), 32'h0, "uart STATUS after clear");
  endtask

  task automatic interrupts();
    byte_t tx_byte;
    addr_t pend;
    pend = reg_addr(`SLOT_GPIO, `REG_IRQ_PEND);
    // earlier done pulses left lines 6 and 7 pending
    write_ok(pend, 32'hff);
    read_check(pend, 0, "IRQ_PEND after clear");
    @(posedge clk);
    gpio_i <= 6'b000100;
    wait_reg(pend, 32'h4, 32'h4);
    repeat (2) @(negedge clk);
    check_value(word_t'(irq), 0, "irq with IRQ_EN clear");
    write_ok(reg_addr(`SLOT_GPIO, `REG_IRQ_EN), 32'h4);
    wait_irq(1'b1);
    write_ok(pend, 32'h4);
    wait_irq(1'b0);
    read_check(pend, 0, "IRQ_PEND bit 2 after clear");
    write_ok(reg_addr(`SLOT_GPIO, `REG_IRQ_EN), 32'hc0);
    next_byte(tx_byte);
    write_ok(reg_addr(`SLOT_UART, `REG_DATA), word_t'(tx_byte));
    wait_reg(pend, 32'hc0, 32'h40);
    wait_irq(1'b1);
    write_ok(reg_addr(`SLOT_UART, `REG_STATUS), 32'h2);
    write_ok(pend, 32'h40);
    wait_irq(1'b0);
    next_byte(tx_byte);
    write_ok(reg_addr(`SLOT_SPI, `REG_DATA), word_t'(tx_byte));
    wait_reg(pend, 32'hc0, 32'h80);
    wait_irq(1'b1);
  endtask

  initial begin
    apb_req = '0;
    gpio_i  = '0;
    wait (rst_n === 1'b1);
    registers_readback();
    decode_error();
    spi_transfer();
    uart_frame();
    interrupts();
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- sim.f
+incdir+logic
logic/periph_pkg.sv
logic/apb_decoder.sv
logic/spi_master.sv
logic/uart_tx.sv
logic/gpio_apb.sv
logic/periph_top.sv
bench/clock_gen.sv
bench/periph_tb.sv
